//--- src/cache_pkg.sv
`default_nettype none

package cache_pkg;

    //======================================================================
    // Widths and geometry
    //======================================================================
    localparam int CODE_ADDR_W = 16;  // Fetch address, counted in codes
    localparam int DATA_ADDR_W = 15;  // Data address, counted in bytes
    localparam int BUS_ADDR_W  = 16;  // External byte address
    localparam int BYTE_W      = 8;
    localparam int CODE_W      = 4;   // One instruction code
    localparam int IC_ENTRIES  = 4;   // Direct mapped
    localparam int LINE_BYTES  = 4;

    localparam logic [CODE_W-1:0] NOP_CODE = 4'hf;

    // Fields of a fetch address, derived from the geometry above
    localparam int LINE_CODES    = LINE_BYTES * BYTE_W / CODE_W;
    localparam int CODE_OFFSET_W = $clog2(LINE_CODES);  // Code position in a line
    localparam int BYTE_OFFSET_W = $clog2(LINE_BYTES);  // Byte position in a line
    localparam int IC_INDEX_W    = $clog2(IC_ENTRIES);
    localparam int IC_TAG_W      = CODE_ADDR_W - IC_INDEX_W - CODE_OFFSET_W;

    //======================================================================
    // Vector types
    //======================================================================
    typedef logic [CODE_ADDR_W-1:0]       code_addr_t;
    typedef logic [DATA_ADDR_W-1:0]       data_addr_t;
    typedef logic [BUS_ADDR_W-1:0]        bus_addr_t;
    typedef logic [BYTE_W-1:0]            byte_t;
    typedef logic [CODE_W-1:0]            code_t;
    typedef logic [LINE_BYTES*BYTE_W-1:0] line_t;  // Byte 0 in the low lane
    typedef logic [IC_TAG_W-1:0]          ic_tag_t;
    typedef logic [IC_INDEX_W-1:0]        ic_index_t;
    typedef logic [CODE_OFFSET_W-1:0]     code_offset_t;

    // One byte transfer on a req/rdy port
    typedef struct packed {
        logic      write;
        bus_addr_t addr;
        byte_t     wdata;  // Don't care on reads
    } bus_cmd_t;

    //======================================================================
    // State machines
    //======================================================================
    typedef enum logic [1:0] {
        IC_IDLE,
        IC_RESPOND,
        IC_FILL
    } ic_state_t;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_BYTE,
        FILL_ACK
    } fill_state_t;

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_DATA,
        GRANT_FILL
    } arb_grant_t;

endpackage

`default_nettype wire

//--- src/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache
(
    input  wire                        CLK,
    input  wire                        RES,
    // Fetch port
    input  wire                        if_req,
    input  wire cache_pkg::code_addr_t if_addr,
    output cache_pkg::code_t           if_code,
    output logic                       if_rdy,
    // Line fill handshake
    output logic                       fill_req,
    output cache_pkg::bus_addr_t       fill_line,
    input  wire                        fill_ack,
    input  wire cache_pkg::line_t      fill_data
);

    //======================================================================
    // Storage
    //======================================================================
    cache_pkg::ic_tag_t              tag_arr  [cache_pkg::IC_ENTRIES];
    cache_pkg::line_t                data_arr [cache_pkg::IC_ENTRIES];
    logic [cache_pkg::IC_ENTRIES-1:0] valid;

    cache_pkg::ic_state_t  state;
    cache_pkg::ic_state_t  state_next;
    cache_pkg::code_addr_t req_addr;  // Address of the accepted fetch

    // Fields of the incoming address, used for the hit check
    cache_pkg::ic_tag_t   in_tag;
    cache_pkg::ic_index_t in_index;
    logic                 hit;
    logic                 accept;

    // Fields of the accepted address
    cache_pkg::ic_tag_t       req_tag;
    cache_pkg::ic_index_t     req_index;
    cache_pkg::code_offset_t  req_offset;
    logic                     line_write;

    assign in_tag   = if_addr[cache_pkg::CODE_ADDR_W-1 -: cache_pkg::IC_TAG_W];
    assign in_index = if_addr[cache_pkg::CODE_OFFSET_W +: cache_pkg::IC_INDEX_W];

    assign req_tag    = req_addr[cache_pkg::CODE_ADDR_W-1 -: cache_pkg::IC_TAG_W];
    assign req_index  = req_addr[cache_pkg::CODE_OFFSET_W +: cache_pkg::IC_INDEX_W];
    assign req_offset = req_addr[cache_pkg::CODE_OFFSET_W-1:0];

    // Only the indexed entry can hold the line
    assign hit    = valid[in_index] && (tag_arr[in_index] == in_tag);
    assign accept = (state == cache_pkg::IC_IDLE) && if_req;

    // Line comes back from the fill engine in one piece
    assign line_write = (state == cache_pkg::IC_FILL) && fill_ack;

    //======================================================================
    // Control
    //======================================================================
    always_comb
    begin
        state_next = state;
        case (state)
            cache_pkg::IC_IDLE:
            begin
                if (if_req)
                    state_next = hit ? cache_pkg::IC_RESPOND : cache_pkg::IC_FILL;
            end
            cache_pkg::IC_RESPOND:
                state_next = cache_pkg::IC_IDLE;  // One answer per request
            cache_pkg::IC_FILL:
            begin
                if (fill_ack)
                    state_next = cache_pkg::IC_RESPOND;
            end
            default:
                state_next = cache_pkg::IC_IDLE;
        endcase
    end

    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            state <= cache_pkg::IC_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            req_addr <= if_addr;
    end

    //======================================================================
    // Array update
    //======================================================================
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            valid <= '0;
        else if (line_write)
            valid[req_index] <= 1'b1;
    end

    // Tag and data change together, so the entry is never half written
    always_ff @(posedge CLK)
    begin
        if (line_write)
        begin
            tag_arr[req_index]  <= req_tag;
            data_arr[req_index] <= fill_data;
        end
    end

    //======================================================================
    // Outputs
    //======================================================================
    assign fill_req  = (state == cache_pkg::IC_FILL);
    assign fill_line = {1'b0,
                        req_addr[cache_pkg::CODE_ADDR_W-1:cache_pkg::CODE_OFFSET_W],
                        {cache_pkg::BYTE_OFFSET_W{1'b0}}};  // Byte 0 of the line

    assign if_rdy = (state == cache_pkg::IC_RESPOND);

    // Code j sits at nibble j, low nibble of each byte first
    always_comb
    begin
        if (if_rdy)
            if_code = data_arr[req_index][req_offset*cache_pkg::CODE_W +: cache_pkg::CODE_W];
        else
            if_code = cache_pkg::NOP_CODE;
    end

endmodule

`default_nettype wire

//--- src/line_fill.sv
`timescale 1ns/1ns
`default_nettype none

module line_fill
(
    input  wire                        CLK,
    input  wire                        RES,
    // Four-phase handshake with the cache
    input  wire                        fill_req,
    input  wire cache_pkg::bus_addr_t  fill_line,
    output logic                       fill_ack,
    output cache_pkg::line_t           fill_data,
    // Byte port towards the arbiter
    output logic                       byte_req,
    output cache_pkg::bus_cmd_t        byte_cmd,
    input  wire                        byte_rdy,
    input  wire cache_pkg::byte_t      byte_rdata
);

    cache_pkg::fill_state_t state;
    cache_pkg::fill_state_t state_next;

    logic [cache_pkg::BYTE_OFFSET_W-1:0] byte_cnt;  // Byte of the line in flight
    logic                                last_byte;
    logic                                byte_done;
    cache_pkg::line_t                    line_buf;

    assign last_byte = &byte_cnt;
    assign byte_done = (state == cache_pkg::FILL_BYTE) && byte_rdy;

    //======================================================================
    // Sequencer
    //======================================================================
    always_comb
    begin
        state_next = state;
        case (state)
            cache_pkg::FILL_IDLE:
            begin
                if (fill_req)
                    state_next = cache_pkg::FILL_BYTE;
            end
            cache_pkg::FILL_BYTE:
            begin
                if (byte_rdy && last_byte)
                    state_next = cache_pkg::FILL_ACK;
            end
            cache_pkg::FILL_ACK:
            begin
                if (!fill_req)  // Cache has taken the line
                    state_next = cache_pkg::FILL_IDLE;
            end
            default:
                state_next = cache_pkg::FILL_IDLE;
        endcase
    end

    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
        begin
            state    <= cache_pkg::FILL_IDLE;
            byte_cnt <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == cache_pkg::FILL_IDLE)
                byte_cnt <= '0;
            else if (byte_done)
                byte_cnt <= byte_cnt + 1'b1;  // Wraps to 0 after the last byte
        end
    end

    // Bytes arrive in rising order, so after four shifts byte 0 is in the low lane
    always_ff @(posedge CLK)
    begin
        if (byte_done)
            line_buf <= {byte_rdata, line_buf[$bits(cache_pkg::line_t)-1:cache_pkg::BYTE_W]};
    end

    //======================================================================
    // Outputs
    //======================================================================
    assign byte_req = (state == cache_pkg::FILL_BYTE);

    always_comb
    begin
        byte_cmd.write = 1'b0;  // Fills only read
        byte_cmd.addr  = {fill_line[cache_pkg::BUS_ADDR_W-1:cache_pkg::BYTE_OFFSET_W], byte_cnt};
        byte_cmd.wdata = '0;
    end

    assign fill_ack  = (state == cache_pkg::FILL_ACK);
    assign fill_data = line_buf;

endmodule

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter
(
    input  wire                        CLK,
    input  wire                        RES,
    // Data port from the CPU
    input  wire                        dm_req,
    input  wire                        dm_write,
    input  wire cache_pkg::data_addr_t dm_addr,
    input  wire cache_pkg::byte_t      dm_wdata,
    output logic                       dm_rdy,
    output cache_pkg::byte_t           dm_rdata,
    // Byte port from the fill engine
    input  wire                        byte_req,
    input  wire cache_pkg::bus_cmd_t   byte_cmd,
    output logic                       byte_rdy,
    output cache_pkg::byte_t           byte_rdata,
    // External bus
    output logic                       bus_req,
    output cache_pkg::bus_cmd_t        bus_cmd,
    input  wire                        bus_rdy,
    input  wire cache_pkg::byte_t      bus_rdata
);

    cache_pkg::arb_grant_t grant;
    cache_pkg::arb_grant_t grant_next;
    cache_pkg::bus_cmd_t   dm_cmd;

    // Data space is the upper half of the bus
    always_comb
    begin
        dm_cmd.write = dm_write;
        dm_cmd.addr  = {1'b1, dm_addr};
        dm_cmd.wdata = dm_wdata;
    end

    //======================================================================
    // Grant
    //======================================================================
    always_comb
    begin
        grant_next = grant;
        case (grant)
            cache_pkg::GRANT_NONE:
            begin
                if (dm_req)  // Data first
                    grant_next = cache_pkg::GRANT_DATA;
                else if (byte_req)
                    grant_next = cache_pkg::GRANT_FILL;
            end
            cache_pkg::GRANT_DATA,
            cache_pkg::GRANT_FILL:
            begin
                if (bus_rdy)
                    grant_next = cache_pkg::GRANT_NONE;
            end
            default:
                grant_next = cache_pkg::GRANT_NONE;
        endcase
    end

    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            grant <= cache_pkg::GRANT_NONE;
        else
            grant <= grant_next;
    end

    //======================================================================
    // Bus side and return path
    //======================================================================
    assign bus_req = (grant != cache_pkg::GRANT_NONE);
    assign bus_cmd = (grant == cache_pkg::GRANT_FILL) ? byte_cmd : dm_cmd;

    // Rdy and read data go back to the granted side only
    assign dm_rdy     = (grant == cache_pkg::GRANT_DATA) && bus_rdy;
    assign byte_rdy   = (grant == cache_pkg::GRANT_FILL) && bus_rdy;
    assign dm_rdata   = (grant == cache_pkg::GRANT_DATA) ? bus_rdata : '0;
    assign byte_rdata = (grant == cache_pkg::GRANT_FILL) ? bus_rdata : '0;

endmodule

`default_nettype wire

//--- src/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top
(
    input  wire                        CLK,
    input  wire                        RES,
    // Instruction fetch
    input  wire                        if_req,
    input  wire cache_pkg::code_addr_t if_addr,
    output cache_pkg::code_t           if_code,
    output logic                       if_rdy,
    // Data access, uncached
    input  wire                        dm_req,
    input  wire                        dm_write,
    input  wire cache_pkg::data_addr_t dm_addr,
    input  wire cache_pkg::byte_t      dm_wdata,
    output cache_pkg::byte_t           dm_rdata,
    output logic                       dm_rdy,
    // External byte bus
    output logic                       bus_req,
    output cache_pkg::bus_cmd_t        bus_cmd,
    input  wire                        bus_rdy,
    input  wire cache_pkg::byte_t      bus_rdata
);

    //======================================================================
    // Internal links
    //======================================================================
    logic                 fill_req;
    cache_pkg::bus_addr_t fill_line;
    logic                 fill_ack;
    cache_pkg::line_t     fill_data;

    logic                 byte_req;  // Fill engine to arbiter
    cache_pkg::bus_cmd_t  byte_cmd;
    logic                 byte_rdy;
    cache_pkg::byte_t     byte_rdata;

    icache icache_inst
    (
        .CLK       (CLK),
        .RES       (RES),
        .if_req    (if_req),
        .if_addr   (if_addr),
        .if_code   (if_code),
        .if_rdy    (if_rdy),
        .fill_req  (fill_req),
        .fill_line (fill_line),
        .fill_ack  (fill_ack),
        .fill_data (fill_data)
    );

    line_fill line_fill_inst
    (
        .CLK        (CLK),
        .RES        (RES),
        .fill_req   (fill_req),
        .fill_line  (fill_line),
        .fill_ack   (fill_ack),
        .fill_data  (fill_data),
        .byte_req   (byte_req),
        .byte_cmd   (byte_cmd),
        .byte_rdy   (byte_rdy),
        .byte_rdata (byte_rdata)
    );

    bus_arbiter bus_arbiter_inst
    (
        .CLK        (CLK),
        .RES        (RES),
        .dm_req     (dm_req),
        .dm_write   (dm_write),
        .dm_addr    (dm_addr),
        .dm_wdata   (dm_wdata),
        .dm_rdy     (dm_rdy),
        .dm_rdata   (dm_rdata),
        .byte_req   (byte_req),
        .byte_cmd   (byte_cmd),
        .byte_rdy   (byte_rdy),
        .byte_rdata (byte_rdata),
        .bus_req    (bus_req),
        .bus_cmd    (bus_cmd),
        .bus_rdy    (bus_rdy),
        .bus_rdata  (bus_rdata)
    );

endmodule

`default_nettype wire

//--- tests/cache_top_properties.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top_properties
(
    input wire                      CLK,
    input wire                      RES,
    input wire                      if_rdy,
    input wire                      dm_rdy,
    input wire                      bus_req,
    input wire cache_pkg::bus_cmd_t bus_cmd,
    input wire                      bus_rdy
);

    int violations = 0;  // Number of failed properties

    //======================================================================
    // Bus command held until the bus takes it
    //======================================================================
    bus_hold: assert property (@(posedge CLK) disable iff (RES)
        bus_req && !bus_rdy |=> bus_req && $stable(bus_cmd))
    else
    begin
        $error("bus_req or bus_cmd changed before bus_rdy");
        violations++;
    end

    // Ready outputs are single pulses
    if_rdy_pulse: assert property (@(posedge CLK) disable iff (RES)
        if_rdy |=> !if_rdy)
    else
    begin
        $error("if_rdy stayed high for more than one cycle");
        violations++;
    end

    dm_rdy_pulse: assert property (@(posedge CLK) disable iff (RES)
        dm_rdy |=> !dm_rdy)
    else
    begin
        $error("dm_rdy stayed high for more than one cycle");
        violations++;
    end

    reset_quiet: assert property (@(posedge CLK) RES |-> !bus_req)
    else
    begin
        $error("bus_req high during reset");
        violations++;
    end

endmodule

bind cache_top cache_top_properties properties_inst (.*);

`default_nettype wire

//--- tests/cache_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int ACCESS_COUNT    = 20;  // Fetches and data accesses issued below
    localparam int WATCHDOG_CYCLES = 200 * ACCESS_COUNT;
    localparam int MEM_HI_SIZE     = 2 ** cache_pkg::DATA_ADDR_W;

    logic                  CLK;
    logic                  RES;
    logic                  if_req;
    cache_pkg::code_addr_t if_addr;
    cache_pkg::code_t      if_code;
    logic                  if_rdy;
    logic                  dm_req;
    logic                  dm_write;
    cache_pkg::data_addr_t dm_addr;
    cache_pkg::byte_t      dm_wdata;
    cache_pkg::byte_t      dm_rdata;
    logic                  dm_rdy;
    logic                  bus_req;
    cache_pkg::bus_cmd_t   bus_cmd;
    logic                  bus_rdy = 1'b0;
    cache_pkg::byte_t      bus_rdata = '0;

    integer seed = 32'h7e173528;
    string  test_name;

    cache_pkg::byte_t mem_hi      [MEM_HI_SIZE];  // Upper half of the bus
    cache_pkg::byte_t data_shadow [MEM_HI_SIZE];  // Expected data contents
    cache_pkg::ic_tag_t model_tag [cache_pkg::IC_ENTRIES];
    logic [cache_pkg::IC_ENTRIES-1:0] model_valid;
    cache_pkg::code_addr_t rand_addr [8];

    // Expectations for the access in flight
    logic                 no_request_yet;
    logic                 expect_hit;
    cache_pkg::code_t     expect_code;
    cache_pkg::byte_t     expect_rdata;
    cache_pkg::bus_addr_t expect_fill_addr;
    logic [1:0]           fill_idx;
    logic [2:0]           fetch_fill_cnt;
    logic                 fill_done;
    logic                 race_start;
    logic                 race_done;

    cache_top cache_top_inst
    (
        .CLK       (CLK),
        .RES       (RES),
        .if_req    (if_req),
        .if_addr   (if_addr),
        .if_code   (if_code),
        .if_rdy    (if_rdy),
        .dm_req    (dm_req),
        .dm_write  (dm_write),
        .dm_addr   (dm_addr),
        .dm_wdata  (dm_wdata),
        .dm_rdata  (dm_rdata),
        .dm_rdy    (dm_rdy),
        .bus_req   (bus_req),
        .bus_cmd   (bus_cmd),
        .bus_rdy   (bus_rdy),
        .bus_rdata (bus_rdata)
    );

    //======================================================================
    // Reference functions and failure reporting
    //======================================================================
    function automatic cache_pkg::byte_t low_half_byte(input cache_pkg::bus_addr_t addr);
        return addr[7:0] ^ addr[15:8];
    endfunction

    function automatic cache_pkg::byte_t upper_half_fill(input cache_pkg::data_addr_t addr);
        return addr[7:0] ^ {1'b0, addr[14:8]} ^ 8'h5a;
    endfunction

    function automatic cache_pkg::code_t code_from_memory(input cache_pkg::code_addr_t addr);
        cache_pkg::byte_t value;
        value = low_half_byte({1'b0, addr[15:1]});
        return addr[0] ? value[7:4] : value[3:0];  // Odd code in the high nibble
    endfunction

    function automatic cache_pkg::byte_t read_memory(input cache_pkg::bus_addr_t addr);
        return addr[15] ? mem_hi[addr[14:0]] : low_half_byte(addr);
    endfunction

    task automatic report_mismatch(input string check, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error in test %s, %s: expected 0x%0h, actual 0x%0h",
                 test_name, check, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("%s (test %s)", what, test_name);
        $display("Test failed");
        $fatal(1);
    endtask

    //======================================================================
    // Clock, memory model and bookkeeping
    //======================================================================
    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(negedge CLK)
    begin
        bus_rdy   = ($random(seed) & 3) != 0;  // Roughly one wait state in four
        bus_rdata = bus_req ? read_memory(bus_cmd.addr) : '0;
    end

    always @(posedge CLK)
    begin
        if (bus_req && bus_rdy && bus_cmd.write && bus_cmd.addr[15])
            mem_hi[bus_cmd.addr[14:0]] <= bus_cmd.wdata;
    end

    assign fill_done        = bus_req && bus_rdy && !dm_rdy;
    assign expect_fill_addr = {1'b0, if_addr[15:3], fill_idx};

    always @(posedge CLK, posedge RES)
    begin
        if (RES)
        begin
            fill_idx       <= '0;
            fetch_fill_cnt <= '0;
            race_done      <= 1'b0;
        end
        else
        begin
            if (fill_done)
            begin
                fill_idx       <= fill_idx + 1'b1;
                fetch_fill_cnt <= fetch_fill_cnt + 1'b1;
            end
            else if (if_rdy)
                fetch_fill_cnt <= '0;
            if (race_start && bus_req && bus_rdy)
                race_done <= 1'b1;  // First transfer after the joint request
        end
    end

    always @(negedge CLK)
    begin
        if (cache_top_inst.properties_inst.violations != 0)
            report_problem("A bus or ready protocol property failed");
    end

    //======================================================================
    // Checks
    //======================================================================
    quiet_after_reset: assert property (@(posedge CLK) disable iff (RES)
        no_request_yet |-> !bus_req && !if_rdy && !dm_rdy)
    else report_mismatch("outputs before any request", 0,
                         {$sampled(bus_req), $sampled(if_rdy), $sampled(dm_rdy)});

    fetch_code: assert property (@(posedge CLK) disable iff (RES)
        if_rdy |-> if_code == expect_code)
    else report_mismatch("fetch code", $sampled(expect_code), $sampled(if_code));

    idle_code: assert property (@(posedge CLK) disable iff (RES)
        !if_rdy |-> if_code == cache_pkg::NOP_CODE)
    else report_mismatch("code without if_rdy", cache_pkg::NOP_CODE, $sampled(if_code));

    fill_count: assert property (@(posedge CLK) disable iff (RES)
        if_rdy |-> fetch_fill_cnt == (expect_hit ? 3'd0 : 3'd4))
    else report_mismatch("fill reads for fetch", expect_hit ? 0 : 4, $sampled(fetch_fill_cnt));

    hit_latency: assert property (@(posedge CLK) disable iff (RES)
        $rose(if_req) && expect_hit |=> if_rdy)
    else report_mismatch("if_rdy one cycle after hit", 1, $sampled(if_rdy));

    hit_no_bus: assert property (@(posedge CLK) disable iff (RES)
        if_req && expect_hit && !dm_req |-> !bus_req)
    else report_mismatch("bus_req during hit", 0, $sampled(bus_req));

    fill_cmd: assert property (@(posedge CLK) disable iff (RES)
        fill_done |-> !bus_cmd.write && bus_cmd.addr == expect_fill_addr)
    else report_mismatch("fill read command", {1'b0, $sampled(expect_fill_addr)},
                         {$sampled(bus_cmd.write), $sampled(bus_cmd.addr)});

    data_cmd: assert property (@(posedge CLK) disable iff (RES)
        dm_rdy |-> bus_req && bus_cmd.addr == {1'b1, dm_addr} && bus_cmd.write == dm_write)
    else report_mismatch("data bus command", {$sampled(dm_write), 1'b1, $sampled(dm_addr)},
                         {$sampled(bus_cmd.write), $sampled(bus_cmd.addr)});

    data_wdata: assert property (@(posedge CLK) disable iff (RES)
        dm_rdy && dm_write |-> bus_cmd.wdata == dm_wdata)
    else report_mismatch("write data on bus", $sampled(dm_wdata), $sampled(bus_cmd.wdata));

    data_rdata: assert property (@(posedge CLK) disable iff (RES)
        dm_rdy && !dm_write |-> dm_rdata == expect_rdata)
    else report_mismatch("data read", $sampled(expect_rdata), $sampled(dm_rdata));

    data_first: assert property (@(posedge CLK) disable iff (RES)
        race_start && !race_done && bus_req |-> bus_cmd.addr[15])
    else report_mismatch("first bus address", {1'b1, $sampled(dm_addr)},
                         $sampled(bus_cmd.addr));

    //======================================================================
    // Stimulus
    //======================================================================
    task automatic fetch(input cache_pkg::code_addr_t addr);
        logic [1:0] index;
        index = addr[4:3];
        @(negedge CLK);
        no_request_yet = 1'b0;
        expect_hit     = model_valid[index] && (model_tag[index] == addr[15:5]);
        expect_code    = code_from_memory(addr);
        if_req         = 1'b1;
        if_addr        = addr;
        do
            @(negedge CLK);
        while (!if_rdy);
        model_valid[index] = 1'b1;  // Line is present from now on
        model_tag[index]   = addr[15:5];
        @(negedge CLK);
        if_req = 0;
    endtask

    task automatic data_access(input logic write, input cache_pkg::data_addr_t addr,
                               input cache_pkg::byte_t wdata);
        @(negedge CLK);
        no_request_yet = 1'b0;
        expect_rdata   = data_shadow[addr];
        dm_req         = 1'b1;
        dm_write       = write;
        dm_addr        = addr;
        dm_wdata       = wdata;
        do
            @(posedge CLK);
        while (!dm_rdy);
        if (write)
            data_shadow[addr] = wdata;
        @(negedge CLK);
        dm_req = 1'b0;
    endtask

    initial
    begin
        RES            = 1'b1;
        if_req         = 1'b0;
        if_addr        = '0;
        dm_req         = 1'b0;
        dm_write       = 1'b0;
        dm_addr        = '0;
        dm_wdata       = '0;
        no_request_yet = 1'b1;
        expect_hit     = 1'b0;
        expect_code    = cache_pkg::NOP_CODE;
        expect_rdata   = '0;
        race_start     = 1'b0;
        model_valid    = '0;
        test_name      = "reset";
        for (int i = 0; i < MEM_HI_SIZE; i++)
        begin
            mem_hi[i]      = upper_half_fill(i);
            data_shadow[i] = upper_half_fill(i);
        end
        for (int i = 0; i < 8; i++)
            rand_addr[i] = $random(seed) & 16'h0c3f;  // Few tags, so hits and misses mix

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RES = 1'b0;

        test_name = "idle after reset";
        repeat (6) @(negedge CLK);

        test_name = "fetch miss";
        fetch(16'h0123);
        test_name = "fetch hit";
        fetch(16'h0120);
        fetch(16'h0127);
        fetch(16'h0125);
        test_name = "refill same index";
        fetch(16'h0923);
        fetch(16'h0121);    // Old tag misses again

        test_name = "data write and read";
        data_access(1'b1, 15'h1234, 8'ha5);
        data_access(1'b0, 15'h1234, 8'h00);
        data_access(1'b1, 15'h7fff, 8'h3c);
        data_access(1'b0, 15'h7fff, 8'h00);

        test_name  = "data before fill";
        race_start = 1'b1;
        fork
            fetch(16'h2456);
            data_access(1'b0, 15'h0042, 8'h00);
        join

        test_name = "random fetches";
        for (int i = 0; i < 8; i++)
            fetch(rand_addr[i]);

        repeat (4) @(negedge CLK);
        if (cache_top_inst.properties_inst.violations != 0)
        begin
            $display("A bus or ready protocol property failed");
            $display("Test failed");
            $fatal(1);
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // Watchdog sized by the number of accesses
    initial
    begin
        #((RESET_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all accesses completed");
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- build.f
src/cache_pkg.sv
src/icache.sv
src/line_fill.sv
src/bus_arbiter.sv
src/cache_top.sv
tests/cache_top_properties.sv
tests/cache_top_tb.sv

//--- Bender.yml
package:
  name: cache_top

sources:
  - target: rtl
    files:
      - src/cache_pkg.sv
      - src/icache.sv
      - src/line_fill.sv
      - src/bus_arbiter.sv
      - src/cache_top.sv

  - target: test
    files:
      - tests/cache_top_properties.sv
      - tests/cache_top_tb.sv
